// File: hdl/degu_pkg.sv
// degu shared definitions for widths, opcodes, ALU codes and instruction formats
package degu_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths and reset vector
  //////////////////////////////////////////////////////////////////////

  localparam int XLEN  = 32;
  localparam int BEN_W = 4;

  // first fetch address after reset
  localparam logic [XLEN-1:0] RST_PC = 32'h0000_0000;

  //////////////////////////////////////////////////////////////////////
  // RV32I major opcodes
  //////////////////////////////////////////////////////////////////////

  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_op     = 7'b0110011;

  //////////////////////////////////////////////////////////////////////
  // ALU operations
  //////////////////////////////////////////////////////////////////////

  // code is {funct7[5], funct3} of the register form
  localparam logic [3:0] alu_add  = 4'b0000;
  localparam logic [3:0] alu_sll  = 4'b0001;
  localparam logic [3:0] alu_slt  = 4'b0010;
  localparam logic [3:0] alu_sltu = 4'b0011;
  localparam logic [3:0] alu_xor  = 4'b0100;
  localparam logic [3:0] alu_srl  = 4'b0101;
  localparam logic [3:0] alu_or   = 4'b0110;
  localparam logic [3:0] alu_and  = 4'b0111;
  localparam logic [3:0] alu_sub  = 4'b1000;
  localparam logic [3:0] alu_sra  = 4'b1101;

  //////////////////////////////////////////////////////////////////////
  // instruction word, one view per format
  //////////////////////////////////////////////////////////////////////

  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm_11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm_11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      logic [6:0] opcode;
    } s;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic [19:0] imm_31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j;
  } instr_t;

endpackage

// File: hdl/degu_decoder.sv
// degu instruction decoder, register addresses, immediate, ALU operation and strobes
`timescale 1ns/10ps

module degu_decoder
  import degu_pkg::*;
(
  input  instr_t          instr,
  output logic [4:0]      rs1_adr,
  output logic [4:0]      rs2_adr,
  output logic [4:0]      rd_adr,
  output logic [XLEN-1:0] imm,
  output logic [3:0]      alu_op,
  output logic            alu_imm,
  output logic            alu_pc,
  output logic            rd_wen,
  output logic            is_branch,
  output logic            is_jal,
  output logic            is_jalr,
  output logic            is_load,
  output logic            is_store,
  output logic            is_lui,
  output logic [2:0]      funct3
);

  always_comb begin
    // register fields sit at the same place in every format
    rs1_adr   = instr.r.rs1;
    rs2_adr   = instr.r.rs2;
    rd_adr    = instr.r.rd;
    funct3    = instr.r.funct3;
    imm       = '0;
    alu_op    = alu_add;
    alu_imm   = 1'b0;
    alu_pc    = 1'b0;
    rd_wen    = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_lui    = 1'b0;
    case (instr.r.opcode)
      opc_lui: begin
        imm    = {instr.u.imm_31_12, 12'h000};
        rd_wen = 1'b1;
        is_lui = 1'b1;
      end
      opc_auipc: begin
        // pc + upper immediate through the ALU adder
        imm     = {instr.u.imm_31_12, 12'h000};
        alu_imm = 1'b1;
        alu_pc  = 1'b1;
        rd_wen  = 1'b1;
      end
      opc_jal: begin
        imm    = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                  instr.j.imm_11, instr.j.imm_10_1, 1'b0};
        rd_wen = 1'b1;
        is_jal = 1'b1;
      end
      opc_jalr: begin
        // target rs1 + imm from the ALU
        imm     = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
        alu_imm = 1'b1;
        rd_wen  = 1'b1;
        is_jalr = 1'b1;
      end
      opc_branch: begin
        imm       = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                     instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
        is_branch = 1'b1;
        // slt picks the signed difference, sub and sltu the unsigned one
        if (!instr.b.funct3[2]) begin
          alu_op = alu_sub;
        end else if (!instr.b.funct3[1]) begin
          alu_op = alu_slt;
        end else begin
          alu_op = alu_sltu;
        end
      end
      opc_load: begin
        imm     = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
        alu_imm = 1'b1;
        rd_wen  = 1'b1;
        is_load = 1'b1;
      end
      opc_store: begin
        imm      = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
        alu_imm  = 1'b1;
        is_store = 1'b1;
      end
      opc_op_imm: begin
        imm     = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
        alu_imm = 1'b1;
        rd_wen  = 1'b1;
        // only srai keeps bit 30, no subi exists
        alu_op  = {(instr.i.funct3 == 3'b101) && instr.i.imm_11_0[10], instr.i.funct3};
      end
      opc_op: begin
        rd_wen = 1'b1;
        alu_op = {instr.r.funct7[5], instr.r.funct3};
      end
      // fence, system and unknown codes act as no-operation
      default: ;
    endcase
  end

endmodule

// File: hdl/degu_gpr.sv
// degu register file, 31 registers with two async read ports and one write port
`timescale 1ns/10ps

module degu_gpr
  import degu_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic [4:0]      rs1_adr,
  input  logic [4:0]      rs2_adr,
  input  logic [4:0]      rd_adr,
  input  logic            rd_wen,
  input  logic [XLEN-1:0] rd_dat,
  output logic [XLEN-1:0] rs1_dat,
  output logic [XLEN-1:0] rs2_dat
);

  // x0 has no storage
  logic [XLEN-1:0] gpr [1:31];

  // no writes while reset is held
  always_ff @(posedge clk) begin
    if (!rst && rd_wen && (rd_adr != 5'd0)) begin
      gpr[rd_adr] <= rd_dat;
    end
  end

  // no bypass, a write shows up on the next cycle
  assign rs1_dat = (rs1_adr == 5'd0) ? '0 : gpr[rs1_adr];
  assign rs2_dat = (rs2_adr == 5'd0) ? '0 : gpr[rs2_adr];

endmodule

// File: hdl/degu_alu.sv
// degu ALU, arithmetic, logic, shift, compare and 33-bit branch difference
`timescale 1ns/10ps

module degu_alu
  import degu_pkg::*;
(
  input  logic [3:0]      alu_op,
  input  logic [XLEN-1:0] op_a,
  input  logic [XLEN-1:0] op_b,
  output logic [XLEN-1:0] res,
  output logic [XLEN:0]   diff
);

  logic       sgn;
  logic [4:0] shamt;

  // signed compare extends both operands by their sign bit
  assign sgn   = (alu_op == alu_slt);
  assign shamt = op_b[4:0];

  // msb is the borrow, i.e. op_a < op_b
  assign diff = {sgn & op_a[XLEN-1], op_a} - {sgn & op_b[XLEN-1], op_b};

  always_comb begin
    case (alu_op)
      alu_add:  res = op_a + op_b;
      alu_sub:  res = diff[XLEN-1:0];
      alu_sll:  res = op_a << shamt;
      // both compares share the difference
      alu_slt,
      alu_sltu: res = {{(XLEN-1){1'b0}}, diff[XLEN]};
      alu_xor:  res = op_a ^ op_b;
      alu_srl:  res = op_a >> shamt;
      alu_sra:  res = $signed(op_a) >>> shamt;
      alu_or:   res = op_a | op_b;
      alu_and:  res = op_a & op_b;
      default:  res = op_a + op_b;
    endcase
  end

endmodule

// File: hdl/degu_lsu.sv
// degu load/store unit, data bus requests and load data alignment
`timescale 1ns/10ps

module degu_lsu
  import degu_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic             run,
  input  logic             is_load,
  input  logic             is_store,
  input  logic [2:0]       funct3,
  input  logic [XLEN-1:0]  adr,
  input  logic [XLEN-1:0]  wdt,
  output logic             lsu_vld,
  output logic             lsu_wen,
  output logic [XLEN-1:0]  lsu_adr,
  output logic [BEN_W-1:0] lsu_ben,
  output logic [XLEN-1:0]  lsu_wdt,
  input  logic             lsu_rdy,
  input  logic [XLEN-1:0]  lsu_rdt,
  output logic [XLEN-1:0]  ld_dat,
  output logic             busy
);

  logic            pend;
  logic [1:0]      pend_off;
  logic [2:0]      pend_siz;
  logic [XLEN-1:0] rdt_sh;

  //////////////////////////////////////////////////////////////////////
  // request
  //////////////////////////////////////////////////////////////////////

  // no new request in the cycle the load data comes back
  assign lsu_vld = run & (is_load | is_store) & ~pend;
  assign lsu_wen = is_store;
  assign lsu_adr = {adr[XLEN-1:2], 2'b00};

  // a load holds the core until its data returns
  assign busy = lsu_vld & ~lsu_wen;

  // byte lanes from size and low address bits
  always_comb begin
    case (funct3[1:0])
      2'b00: begin
        lsu_ben = BEN_W'(1) << adr[1:0];
        lsu_wdt = {4{wdt[7:0]}};
      end
      2'b01: begin
        lsu_ben = BEN_W'(3) << {adr[1], 1'b0};
        lsu_wdt = {2{wdt[15:0]}};
      end
      default: begin
        lsu_ben = '1;
        lsu_wdt = wdt;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // load return
  //////////////////////////////////////////////////////////////////////

  // set by a load transfer, read data arrives the next cycle
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pend <= 1'b0;
    end else begin
      pend <= lsu_vld & lsu_rdy & ~lsu_wen;
    end
  end

  // offset and size kept for the return cycle
  always_ff @(posedge clk) begin
    if (lsu_vld && lsu_rdy) begin
      pend_off <= adr[1:0];
      pend_siz <= funct3;
    end
  end

  assign rdt_sh = lsu_rdt >> {pend_off, 3'b000};

  // funct3[2] selects zero extension
  always_comb begin
    case (pend_siz[1:0])
      2'b00:   ld_dat = {{24{~pend_siz[2] & rdt_sh[7]}}, rdt_sh[7:0]};
      2'b01:   ld_dat = {{16{~pend_siz[2] & rdt_sh[15]}}, rdt_sh[15:0]};
      default: ld_dat = rdt_sh;
    endcase
  end

endmodule

// File: hdl/degu_core.sv
// degu RV32I core top, fetch control, program counter and write-back
`timescale 1ns/10ps

module degu_core
  import degu_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  // instruction fetch
  output logic             ifu_vld,
  output logic [XLEN-1:0]  ifu_adr,
  input  logic             ifu_rdy,
  input  logic [XLEN-1:0]  ifu_rdt,
  // load/store
  output logic             lsu_vld,
  output logic             lsu_wen,
  output logic [XLEN-1:0]  lsu_adr,
  output logic [BEN_W-1:0] lsu_ben,
  output logic [XLEN-1:0]  lsu_wdt,
  input  logic             lsu_rdy,
  input  logic [XLEN-1:0]  lsu_rdt
);

  // fetch and decode
  logic            run;
  logic            idu_vld;
  logic            ifu_trn;
  logic            ifu_new;
  logic [XLEN-1:0] ir_q;
  logic [XLEN-1:0] instr;
  logic            stall;
  logic            retire;

  // program counter
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] pc_nxt;
  logic [XLEN-1:0] pc_inc;
  logic [XLEN-1:0] pc_add;
  logic            tkn;

  // decoder outputs
  logic [4:0]      rs1_adr;
  logic [4:0]      rs2_adr;
  logic [4:0]      rd_adr;
  logic [XLEN-1:0] imm;
  logic [3:0]      alu_op;
  logic            alu_imm;
  logic            alu_pc;
  logic            rd_wen;
  logic            is_branch;
  logic            is_jal;
  logic            is_jalr;
  logic            is_load;
  logic            is_store;
  logic            is_lui;
  logic [2:0]      funct3;

  // datapath
  logic [XLEN-1:0] rs1_dat;
  logic [XLEN-1:0] rs2_dat;
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_res;
  logic [XLEN:0]   alu_diff;
  logic [XLEN-1:0] ld_dat;
  logic            lsu_busy;
  logic [XLEN-1:0] wb_dat;

  //////////////////////////////////////////////////////////////////////
  // fetch
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      run     <= 1'b0;
      idu_vld <= 1'b0;
      ifu_new <= 1'b0;
    end else begin
      run     <= 1'b1;
      idu_vld <= ifu_trn | (idu_vld & stall);
      ifu_new <= ifu_trn;
    end
  end

  // fetch waits while the instruction in decode stalls on data
  assign ifu_vld = run & ~(idu_vld & stall);
  assign ifu_trn = ifu_vld & ifu_rdy;

  // empty decode slot fetches at pc, otherwise at the next pc
  assign ifu_adr = idu_vld ? pc_nxt : pc;

  // fetched word is valid for one cycle only, keep a copy for stalls
  assign instr = ifu_new ? ifu_rdt : ir_q;

  always_ff @(posedge clk) begin
    ir_q <= instr;
  end

  //////////////////////////////////////////////////////////////////////
  // stall and program counter
  //////////////////////////////////////////////////////////////////////

  // data request waiting or load in flight
  // a waiting fetch leaves decode empty instead
  assign stall  = (lsu_vld & ~lsu_rdy) | lsu_busy;
  assign retire = idu_vld & ~stall;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= RST_PC;
    end else if (retire) begin
      pc <= pc_nxt;
    end
  end

  assign pc_inc = pc + XLEN'(4);
  assign pc_add = pc + imm;

  // eq/ne on zero difference, lt/ge on the borrow bit
  assign tkn = is_branch &
               ((funct3[2] ? alu_diff[XLEN] : (alu_diff[XLEN-1:0] == '0)) ^ funct3[0]);

  always_comb begin
    if (is_jalr) begin
      pc_nxt = {alu_res[XLEN-1:1], 1'b0};
    end else if (is_jal || tkn) begin
      pc_nxt = pc_add;
    end else begin
      pc_nxt = pc_inc;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // decode and execute
  //////////////////////////////////////////////////////////////////////

  degu_decoder u_decoder (
    .instr     (instr),
    .rs1_adr   (rs1_adr),
    .rs2_adr   (rs2_adr),
    .rd_adr    (rd_adr),
    .imm       (imm),
    .alu_op    (alu_op),
    .alu_imm   (alu_imm),
    .alu_pc    (alu_pc),
    .rd_wen    (rd_wen),
    .is_branch (is_branch),
    .is_jal    (is_jal),
    .is_jalr   (is_jalr),
    .is_load   (is_load),
    .is_store  (is_store),
    .is_lui    (is_lui),
    .funct3    (funct3)
  );

  // load data returns in the retire cycle, so one write enable covers all
  degu_gpr u_gpr (
    .clk     (clk),
    .rst     (rst),
    .rs1_adr (rs1_adr),
    .rs2_adr (rs2_adr),
    .rd_adr  (rd_adr),
    .rd_wen  (retire & rd_wen),
    .rd_dat  (wb_dat),
    .rs1_dat (rs1_dat),
    .rs2_dat (rs2_dat)
  );

  assign op_a = alu_pc  ? pc  : rs1_dat;
  assign op_b = alu_imm ? imm : rs2_dat;

  degu_alu u_alu (
    .alu_op (alu_op),
    .op_a   (op_a),
    .op_b   (op_b),
    .res    (alu_res),
    .diff   (alu_diff)
  );

  // address is rs1 + imm from the ALU
  degu_lsu u_lsu (
    .clk      (clk),
    .rst      (rst),
    .run      (idu_vld),
    .is_load  (is_load),
    .is_store (is_store),
    .funct3   (funct3),
    .adr      (alu_res),
    .wdt      (rs2_dat),
    .lsu_vld  (lsu_vld),
    .lsu_wen  (lsu_wen),
    .lsu_adr  (lsu_adr),
    .lsu_ben  (lsu_ben),
    .lsu_wdt  (lsu_wdt),
    .lsu_rdy  (lsu_rdy),
    .lsu_rdt  (lsu_rdt),
    .ld_dat   (ld_dat),
    .busy     (lsu_busy)
  );

  //////////////////////////////////////////////////////////////////////
  // write back
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (is_load) begin
      wb_dat = ld_dat;
    end else if (is_lui) begin
      wb_dat = imm;
    end else if (is_jal || is_jalr) begin
      // link address
      wb_dat = pc_inc;
    end else begin
      wb_dat = alu_res;
    end
  end

endmodule

// File: sim/degu_tb.sv
// degu core testbench that runs the pattern program and checks every data store
`timescale 1ns/10ps

module degu_tb
  import degu_pkg::*;
;

  localparam int TIMEOUT = 3000;

  logic             clk = 1'b0;
  logic             rst;
  logic             ifu_vld;
  logic [XLEN-1:0]  ifu_adr;
  logic             ifu_rdy;
  logic [XLEN-1:0]  ifu_rdt;
  logic             lsu_vld;
  logic             lsu_wen;
  logic [XLEN-1:0]  lsu_adr;
  logic [BEN_W-1:0] lsu_ben;
  logic [XLEN-1:0]  lsu_wdt;
  logic             lsu_rdy;
  logic [XLEN-1:0]  lsu_rdt;

  // instruction and data memory of 1 KiB each
  logic [31:0] imem [0:255];
  logic [31:0] dmem [0:255];
  logic [31:0] dmem_init [0:255];

  // expected stores
  int          exp_grp [$];
  logic [31:0] exp_adr [$];
  logic [3:0]  exp_ben [$];
  logic [31:0] exp_dat [$];

  int          idx;
  int          run_no;
  int          pass_cnt;
  int          fail_cnt;
  bit          grp_bad;
  bit          back_pressure;
  bit          if_xfer;
  bit          ld_xfer;
  logic [31:0] if_adr_q;
  logic [31:0] ld_adr_q;

  always #5 clk = ~clk;

  degu_core UUT (
    .clk     (clk),
    .rst     (rst),
    .ifu_vld (ifu_vld),
    .ifu_adr (ifu_adr),
    .ifu_rdy (ifu_rdy),
    .ifu_rdt (ifu_rdt),
    .lsu_vld (lsu_vld),
    .lsu_wen (lsu_wen),
    .lsu_adr (lsu_adr),
    .lsu_ben (lsu_ben),
    .lsu_wdt (lsu_wdt),
    .lsu_rdy (lsu_rdy),
    .lsu_rdt (lsu_rdt)
  );

  function automatic string group_name(input int grp);
    case (grp)
      2:       return "alu results";
      3:       return "load and store sizes";
      default: return "branches and jumps";
    endcase
  endfunction

  function automatic logic [31:0] lane_mask(input logic [3:0] ben);
    return {{8{ben[3]}}, {8{ben[2]}}, {8{ben[1]}}, {8{ben[0]}}};
  endfunction

  task automatic report_group(input int grp);
    if (grp_bad) begin
      fail_cnt++;
      $display("%s, run %0d: FAILED", group_name(grp), run_no);
    end else begin
      pass_cnt++;
      $display("%s, run %0d: ok", group_name(grp), run_no);
    end
    grp_bad = 1'b0;
  endtask

  task automatic load_patterns();
    int    fd;
    int    n;
    byte   kind;
    string line;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    logic [31:0] f4;
    for (int i = 0; i < 256; i++) begin
      // unused words are addi x0, x0 with the word index as immediate
      imem[i]      = {4'h0, i[7:0], 20'h0_0013};
      dmem_init[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3};
    end
    fd = $fopen("sim/degu_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open the pattern file");
      fail_cnt++;
      return;
    end
    while ($fgets(line, fd)) begin
      if (line.len() > 2 && line.getc(0) != "#") begin
        n = $sscanf(line, "%c %h %h %h %h", kind, f1, f2, f3, f4);
        if (kind == "p") begin
          imem[f1[9:2]] = f2;
        end else if (kind == "d") begin
          dmem_init[f1[9:2]] = f2;
        end else if (kind == "s" && n == 5) begin
          exp_grp.push_back(int'(f1));
          exp_adr.push_back(f2);
          exp_ben.push_back(f3[3:0]);
          exp_dat.push_back(f4);
        end
      end
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////////////////////////////////
  // memory models and store checks
  ////////////////////////////////////////////////////////////////////

  initial begin
    ifu_rdy = 1'b0;
    ifu_rdt = '0;
    lsu_rdy = 1'b0;
    lsu_rdt = '0;
    if_xfer = 1'b0;
    ld_xfer = 1'b0;
    void'($urandom(32'hdedc_e320));
    forever begin
      @(negedge clk);
      // read data one cycle after the transfer
      if (if_xfer) ifu_rdt = imem[if_adr_q[9:2]];
      if (ld_xfer) lsu_rdt = dmem[ld_adr_q[9:2]];
      ifu_rdy = !back_pressure || (($urandom % 4) != 0);
      lsu_rdy = !back_pressure || (($urandom % 4) != 0);
      // sample just before the rising edge
      #4;
      if_xfer  = ifu_vld && ifu_rdy;
      if_adr_q = ifu_adr;
      ld_xfer  = lsu_vld && lsu_rdy && !lsu_wen;
      ld_adr_q = lsu_adr;
      if (lsu_vld && lsu_rdy && lsu_wen) begin
        dmem[lsu_adr[9:2]] = (dmem[lsu_adr[9:2]] & ~lane_mask(lsu_ben)) |
                             (lsu_wdt & lane_mask(lsu_ben));
        if (idx >= exp_adr.size()) begin
          $display("unexpected store to %h after the last expected one", lsu_adr);
          fail_cnt++;
        end else begin
          if (lsu_adr != exp_adr[idx]) begin
            $display("Error: lsu_adr got %h expected %h", lsu_adr, exp_adr[idx]);
            grp_bad = 1'b1;
          end
          if (lsu_ben != exp_ben[idx]) begin
            $display("Error: lsu_ben got %h expected %h", lsu_ben, exp_ben[idx]);
            grp_bad = 1'b1;
          end
          if ((lsu_wdt & lane_mask(exp_ben[idx])) != exp_dat[idx]) begin
            $display("Error: lsu_wdt got %h expected %h", lsu_wdt, exp_dat[idx]);
            grp_bad = 1'b1;
          end
          idx++;
          if (idx == exp_adr.size() || exp_grp[idx] != exp_grp[idx-1]) begin
            report_group(exp_grp[idx-1]);
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////

  initial begin
    int  cnt;
    bit  rst_bad;
    rst      = 1'b1;
    pass_cnt = 0;
    fail_cnt = 0;
    load_patterns();
    // run 0 without back-pressure, run 1 with it
    for (run_no = 0; run_no < 2; run_no++) begin
      back_pressure = (run_no == 1);
      @(negedge clk);
      rst     = 1'b1;
      rst_bad = 1'b0;
      idx     = 0;
      grp_bad = 1'b0;
      for (int i = 0; i < 256; i++) dmem[i] = dmem_init[i];
      repeat (2) begin
        @(negedge clk);
        if (ifu_vld || lsu_vld) begin
          $display("Error: ifu_vld/lsu_vld got %h/%h expected 0/0", ifu_vld, lsu_vld);
          rst_bad = 1'b1;
        end
      end
      rst = 1'b0;
      cnt = 0;
      @(negedge clk);
      #2;
      while (!ifu_vld && cnt < TIMEOUT) begin
        @(negedge clk);
        #2;
        cnt++;
      end
      if (!ifu_vld) begin
        $display("no fetch request came after reset");
        rst_bad = 1'b1;
      end else if (ifu_adr != RST_PC) begin
        $display("Error: ifu_adr got %h expected %h", ifu_adr, RST_PC);
        rst_bad = 1'b1;
      end
      if (rst_bad) fail_cnt++;
      else pass_cnt++;
      $display("reset, run %0d: %s", run_no, rst_bad ? "FAILED" : "ok");
      // all expected stores must show up
      cnt = 0;
      while (idx < exp_adr.size() && cnt < TIMEOUT) begin
        @(negedge clk);
        cnt++;
      end
      if (idx < exp_adr.size()) begin
        $display("run %0d timed out waiting for store %0d of %0d",
                 run_no, idx + 1, exp_adr.size());
        fail_cnt++;
      end
      repeat (10) @(negedge clk);
    end
    $display("summary: %0d ok, %0d bad", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: build.f
hdl/degu_pkg.sv
hdl/degu_decoder.sv
hdl/degu_gpr.sv
hdl/degu_alu.sv
hdl/degu_lsu.sv
hdl/degu_core.sv
sim/degu_tb.sv

// File: Makefile
# Verilator build and run for the degu core testbench

VERILATOR ?= verilator
TOP       ?= degu_tb
RTL_TOP   ?= degu_core
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall
PASS_MSG  ?= test passed

RTL_FILES := $(filter hdl/%,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run fails unless the pass line shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(OBJ_DIR)

// File: sim/degu_patterns.txt
# p <byte address> <instruction word>
# d <byte address> <data word>   s <group> <address> <byte enables> <lane data>
d 100 80FF7F85
p 000 123450B7
p 004 67808093
p 008 20102023
p 00C 00001117
p 010 20202223
p 014 FFB00193
p 018 40308233
p 01C 20402423
p 020 4011D293
p 024 0030B333
p 028 0030A3B3
p 02C 0062C433
p 030 00409493
p 034 0060D533
p 038 00A4F5B3
p 03C 0065E633
p 040 20802623
p 044 20702823
p 048 20902A23
p 04C 20A02C23
p 050 20C02E23
p 054 10000683
p 058 10304703
p 05C 10201783
p 060 10005803
p 064 22D000A3
p 068 22E001A3
p 06C 22F01223
p 070 23001323
p 074 22D02423
p 078 0107C8B3
p 07C 22E02623
p 080 23102823
p 084 00000993
p 088 00630463
p 08C 10098993
p 090 00730463
p 094 00198993
p 098 00731463
p 09C 10098993
p 0A0 00109463
p 0A4 00198993
p 0A8 0011C463
p 0AC 10098993
p 0B0 0030C463
p 0B4 00198993
p 0B8 0030D463
p 0BC 10098993
p 0C0 0011D463
p 0C4 00198993
p 0C8 0030E463
p 0CC 10098993
p 0D0 0011E463
p 0D4 00198993
p 0D8 0011F463
p 0DC 10098993
p 0E0 0030F463
p 0E4 00198993
p 0E8 23302C23
p 0EC 00800A6F
p 0F0 22302E23
p 0F4 00DA0AE7
p 0F8 22302E23
p 0FC 25402023
p 100 25502223
p 104 0000006F
s 2 200 F 12345678
s 2 204 F 0000100C
s 2 208 F 1234567D
s 2 20C F FFFFFFFC
s 2 210 F 00000000
s 2 214 F 23456780
s 2 218 F 091A2B3C
s 2 21C F 01002301
s 3 220 2 00008500
s 3 220 8 80000000
s 3 224 3 000080FF
s 3 224 C 7F850000
s 3 228 F FFFFFF85
s 3 22C F 00000080
s 3 230 F FFFFFF7A
s 4 238 F 00000006
s 4 240 F 000000F0
s 4 244 F 000000F8
